/* synth_voices.f */
+incdir+include
hw/synth_pkg.sv
hw/synth_control.sv
hw/note_voice.sv
hw/voice_mixer.sv
hw/synth_top.sv
sim/tb_synth.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_synth \
    -f synth_voices.f -o tb_synth_sim

output=$(./obj_dir/tb_synth_sim)
echo "$output"

# the run passes only if the pass line was printed
echo "$output" | grep -F -q '*** PASSED ***'

/* include/synth_tb_model.svh */
`ifndef SYNTH_TB_MODEL_SVH
`define SYNTH_TB_MODEL_SVH

function automatic logic [synth_pkg::PHASE_W-1:0] model_phase_step(
    input logic [synth_pkg::PHASE_W-1:0] phase,
    input logic [synth_pkg::NOTE_W-1:0]  note
);
    return phase + synth_pkg::note_increment(note);
endfunction

function automatic logic [7:0] model_lfsr_seed(input logic [synth_pkg::NOTE_W-1:0] note);
    return synth_pkg::LFSR_SEED ^ 8'(note);
endfunction

function automatic logic [7:0] model_lfsr_step(input logic [7:0] lfsr);
    return {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
endfunction

// one voice's sample, zero when its key is up
function automatic logic signed [synth_pkg::SAMPLE_W-1:0] model_wave(
    input synth_pkg::osc_shape_t         shape,
    input logic [synth_pkg::PHASE_W-1:0] phase,
    input logic [7:0]                    lfsr,
    input logic                          gate
);
    if (!gate) return '0;
    case (shape)
        synth_pkg::SHAPE_SQUARE: return phase[synth_pkg::PHASE_W-1] ? -8'sd127 : 8'sd127;
        synth_pkg::SHAPE_SAW:    return $signed(phase[synth_pkg::PHASE_W-1 -: 8]);
        synth_pkg::SHAPE_NOISE:  return $signed(lfsr);
        default:                 return '0;
    endcase
endfunction

function automatic logic signed [synth_pkg::SAMPLE_W+synth_pkg::NOTE_W-1:0] model_mix(
    input logic signed [synth_pkg::SAMPLE_W+synth_pkg::NOTE_W-1:0] sum,
    input logic [synth_pkg::VOLUME_W-1:0]                        volume
);
    logic [synth_pkg::VOLUME_W-1:0] shift;

    shift = 2'd3 - volume;
    return sum >>> shift;
endfunction

`endif

/* sim/tb_synth.sv */
`timescale 1ns/1ps

module tb_synth;

    localparam int NUM_VOICES = 8;
    localparam int MIX_W      = synth_pkg::SAMPLE_W + synth_pkg::NOTE_W;
    localparam int WAIT_LIMIT = 100;   // longer than the 40 cycle sample period

    logic                       clk = 1'b0;
    logic                       reset;
    synth_pkg::key_event_t      key;
    logic                       set_settings;
    synth_pkg::synth_settings_t settings;
    logic                       sample_clock;
    logic signed [MIX_W-1:0]    audio;
    logic                       audio_valid;

    // reference model state
    logic [synth_pkg::PHASE_W-1:0] m_phase [NUM_VOICES];
    logic [7:0]                    m_lfsr [NUM_VOICES];
    logic [NUM_VOICES-1:0]         m_gate;
    logic [NUM_VOICES-1:0]         m_restart;
    synth_pkg::osc_shape_t         m_shape;
    logic [synth_pkg::VOLUME_W-1:0] m_volume;
    logic                          m_prev_sc;
    logic                          tick_pending;
    logic                          stage_valid;
    logic signed [MIX_W-1:0]       stage_sum;
    logic                          m_valid;
    logic signed [MIX_W-1:0]       m_audio;
    int                            cycle_count;
    int                            e0_cycle;

    int          mismatches = 0;
    int          other_errors = 0;
    string       test_name = "reset";
    logic [31:0] lcg_state;
    int          sc_count;

    `include "synth_tb_model.svh"

    synth_top #(
        .NUM_VOICES(NUM_VOICES)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .key          (key),
        .set_settings (set_settings),
        .settings     (settings),
        .sample_clock (sample_clock),
        .audio        (audio),
        .audio_valid  (audio_valid)
    );

    always #5 clk = ~clk;

    initial begin : sample_clock_gen
        sample_clock = 1'b0;
        sc_count     = 0;
        forever begin
            @(posedge clk);
            if (reset) begin
                sc_count = 0;
            end else if (sc_count == 19) begin
                sc_count = 0;
                #1;
                sample_clock = ~sample_clock;
            end else begin
                sc_count = sc_count + 1;
            end
        end
    end

    always @(posedge clk) begin : reference_model
        logic signed [MIX_W-1:0] sum;
        if (reset) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                m_phase[v] = '0;
                m_lfsr[v]  = model_lfsr_seed(3'(v));
            end
            m_gate       = '0;
            m_restart    = '0;
            m_shape      = synth_pkg::SHAPE_SQUARE;
            m_volume     = 2'd3;
            m_prev_sc    = 1'b1;
            tick_pending = 1'b0;
            stage_valid  = 1'b0;
            stage_sum    = '0;
            cycle_count  = 0;
            e0_cycle     = 0;
            m_valid     <= 1'b0;
            m_audio     <= '0;
        end else begin
            cycle_count = cycle_count + 1;
            m_valid <= stage_valid;          // mixer output at E2
            if (stage_valid) begin
                m_audio <= model_mix(stage_sum, m_volume);
            end
            stage_valid = tick_pending;      // voices sample then advance at E1
            if (tick_pending) begin
                sum = '0;
                for (int v = 0; v < NUM_VOICES; v++) begin
                    sum = sum + MIX_W'(model_wave(m_shape, m_phase[v], m_lfsr[v], m_gate[v]));
                    if (m_gate[v]) begin
                        m_phase[v] = model_phase_step(m_phase[v], 3'(v));
                        m_lfsr[v]  = model_lfsr_step(m_lfsr[v]);
                    end
                end
                stage_sum = sum;
            end
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (m_restart[v]) begin
                    m_phase[v] = '0;
                end
            end
            m_restart    = '0;
            tick_pending = sample_clock & ~m_prev_sc;   // E0
            if (tick_pending) begin
                e0_cycle = cycle_count;
            end
            m_prev_sc = sample_clock;
            if (key.press) begin
                m_gate[key.note]    = 1'b1;
                m_restart[key.note] = 1'b1;
            end else if (key.rel) begin
                m_gate[key.note] = 1'b0;
            end
            if (set_settings) begin
                m_shape  = settings.shape;
                m_volume = settings.volume;
            end
        end
    end

    audio_value_check: assert property (@(negedge clk) disable iff (reset)
        audio_valid |-> audio == m_audio)
    else begin
        mismatches++;
        $display("Mismatch %s: expected %0d, actual %0d", test_name, m_audio, audio);
    end

    valid_timing_check: assert property (@(negedge clk) disable iff (reset)
        audio_valid == m_valid)
    else begin
        other_errors++;
        if (audio_valid) begin
            $display("audio_valid high at %0t without a sample clock rise 2 cycles before (%s)",
                     $time, test_name);
        end else begin
            $display("audio_valid missing at %0t 2 cycles after a sample clock rise (%s)",
                     $time, test_name);
        end
    end

    valid_pulse_check: assert property (@(negedge clk) disable iff (reset)
        audio_valid |-> !$past(audio_valid))
    else begin
        other_errors++;
        $display("audio_valid high for two cycles in a row at %0t (%s)", $time, test_name);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [synth_pkg::NOTE_W-1:0] draw_note();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[18:16];
    endfunction

    task automatic press_key(input logic [synth_pkg::NOTE_W-1:0] note);
        @(posedge clk);
        #1;
        key = '{press: 1'b1, rel: 1'b0, note: note};
        @(posedge clk);
        #1;
        key = '0;
    endtask

    task automatic release_key(input logic [synth_pkg::NOTE_W-1:0] note);
        @(posedge clk);
        #1;
        key = '{press: 1'b0, rel: 1'b1, note: note};
        @(posedge clk);
        #1;
        key = '0;
    endtask

    task automatic write_settings(input synth_pkg::osc_shape_t shape,
                                  input logic [synth_pkg::VOLUME_W-1:0] volume);
        @(posedge clk);
        #1;
        set_settings = 1'b1;
        settings     = '{shape: shape, volume: volume};
        @(posedge clk);
        #1;
        set_settings = 1'b0;
    endtask

    // returns on the negedge where audio_valid is seen high
    task automatic wait_samples(input int count);
        int waited;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            @(negedge clk);
            while (!audio_valid && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!audio_valid) begin
                other_errors++;
                $display("Timeout: no audio_valid within %0d cycles (%s)", WAIT_LIMIT, test_name);
            end
        end
    endtask

    initial begin : main
        logic [synth_pkg::NOTE_W-1:0] lone_note;
        logic [synth_pkg::NOTE_W-1:0] chord [3];
        reset        = 1'b1;
        key          = '0;
        set_settings = 1'b0;
        settings     = '{shape: synth_pkg::SHAPE_SQUARE, volume: 2'd3};
        lcg_state    = 32'h82ab_aebc;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "idle";
        wait_samples(1);
        latency_check: assert (cycle_count - e0_cycle == 2)
        else begin
            mismatches++;
            $display("Mismatch %s latency: expected 2, actual %0d", test_name,
                     cycle_count - e0_cycle);
        end
        silence_check: assert (audio == '0)
        else begin
            mismatches++;
            $display("Mismatch %s: expected 0, actual %0d", test_name, audio);
        end

        test_name = "square";
        lone_note = draw_note();
        press_key(lone_note);
        wait_samples(40);   // long enough for the phase MSB to flip
        release_key(lone_note);
        wait_samples(1);

        test_name = "saw";
        write_settings(synth_pkg::SHAPE_SAW, 2'd3);
        chord[0] = draw_note();
        chord[1] = chord[0];
        for (int g = 0; g < 64 && chord[1] == chord[0]; g++) begin
            chord[1] = draw_note();
        end
        chord[2] = chord[0];
        for (int g = 0; g < 64 && (chord[2] == chord[0] || chord[2] == chord[1]); g++) begin
            chord[2] = draw_note();
        end
        for (int c = 0; c < 3; c++) begin
            press_key(chord[c]);
        end
        wait_samples(12);

        test_name = "noise";
        lcg_state = lcg_next(lcg_state);
        write_settings(synth_pkg::SHAPE_NOISE, lcg_state[21:20]);
        wait_samples(8);
        release_key(chord[1]);
        wait_samples(8);
        press_key(chord[1]);   // lfsr carries on from where it stopped
        wait_samples(8);

        test_name = "volume";
        for (int v = 0; v < 4; v++) begin
            write_settings(synth_pkg::SHAPE_SAW, 2'(v));
            wait_samples(4);
        end

        test_name = "release";
        for (int c = 0; c < 3; c++) begin
            release_key(chord[c]);
        end
        wait_samples(2);

        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* hw/synth_top.sv */
`timescale 1ns/1ps

module synth_top #(
    parameter int NUM_VOICES = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  synth_pkg::key_event_t      key,
    input  logic                       set_settings,
    input  synth_pkg::synth_settings_t settings,
    input  logic                       sample_clock,
    output logic signed [synth_pkg::SAMPLE_W+synth_pkg::NOTE_W-1:0] audio,
    output logic                       audio_valid
);

    synth_pkg::voice_ctrl_t                ctrl;
    logic [NUM_VOICES-1:0]                 gate;
    logic [NUM_VOICES-1:0]                 restart;
    logic [synth_pkg::VOLUME_W-1:0]        volume;
    logic signed [synth_pkg::SAMPLE_W-1:0] voice_sample [NUM_VOICES];
    logic [NUM_VOICES-1:0]                 voice_valid;

    synth_control #(
        .NUM_VOICES(NUM_VOICES)
    ) u_control (
        .clk          (clk),
        .reset        (reset),
        .key          (key),
        .set_settings (set_settings),
        .settings     (settings),
        .sample_clock (sample_clock),
        .ctrl         (ctrl),
        .gate         (gate),
        .restart      (restart),
        .volume       (volume)
    );

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
        note_voice #(
            .NUM_VOICES  (NUM_VOICES),
            .VOICE_INDEX (i)
        ) u_voice (
            .clk          (clk),
            .reset        (reset),
            .ctrl         (ctrl),
            .gate         (gate[i]),
            .restart      (restart[i]),
            .sample       (voice_sample[i]),
            .sample_valid (voice_valid[i])
        );
    end

    // all voices tick together so voice 0 speaks for the set
    voice_mixer #(
        .NUM_VOICES(NUM_VOICES)
    ) u_mixer (
        .clk          (clk),
        .reset        (reset),
        .sample       (voice_sample),
        .sample_valid (voice_valid[0]),
        .volume       (volume),
        .audio        (audio),
        .audio_valid  (audio_valid)
    );

endmodule

/* hw/voice_mixer.sv */
`timescale 1ns/1ps

module voice_mixer #(
    parameter int NUM_VOICES = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic signed [synth_pkg::SAMPLE_W-1:0] sample [NUM_VOICES],
    input  logic                                  sample_valid,
    input  logic [synth_pkg::VOLUME_W-1:0]        volume,
    output logic signed [synth_pkg::SAMPLE_W+synth_pkg::NOTE_W-1:0] audio,
    output logic                                  audio_valid
);

    localparam int MIX_W    = synth_pkg::SAMPLE_W + synth_pkg::NOTE_W;
    localparam int VOLUME_W = synth_pkg::VOLUME_W;

    localparam logic [VOLUME_W-1:0] MAX_VOLUME = '1;

    logic signed [MIX_W-1:0] sum;
    logic [VOLUME_W-1:0]     shift;

    // room for eight full scale voices
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            sum = sum + MIX_W'(sample[i]);
        end
    end

    assign shift = MAX_VOLUME - volume;   // 3 - volume

    always_ff @(posedge clk) begin
        if (reset) begin
            audio_valid <= 1'b0;
        end else begin
            audio_valid <= sample_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            audio <= sum >>> shift;  // keeps sign
        end
    end

endmodule

/* hw/note_voice.sv */
`timescale 1ns/1ps

module note_voice #(
    parameter int NUM_VOICES  = 8,
    parameter int VOICE_INDEX = 0
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  synth_pkg::voice_ctrl_t                ctrl,
    input  logic                                  gate,
    input  logic                                  restart,
    output logic signed [synth_pkg::SAMPLE_W-1:0] sample,
    output logic                                  sample_valid
);

    localparam int PHASE_W  = synth_pkg::PHASE_W;
    localparam int SAMPLE_W = synth_pkg::SAMPLE_W;
    localparam int NOTE_W   = synth_pkg::NOTE_W;

    localparam int NOTE = VOICE_INDEX % NUM_VOICES;

    localparam logic [PHASE_W-1:0] STEP =
        synth_pkg::note_increment(NOTE[NOTE_W-1:0]);

    localparam logic [7:0] SEED = synth_pkg::LFSR_SEED ^ 8'(NOTE);

    localparam logic signed [SAMPLE_W-1:0] SQUARE_HI = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] SQUARE_LO = -SQUARE_HI;

    logic [PHASE_W-1:0]         phase;
    logic [7:0]                 lfsr;
    logic                       lfsr_fb;
    logic                       advance;
    logic signed [SAMPLE_W-1:0] wave;

    assign advance = ctrl.tick & gate;

    // fibonacci taps 7 5 4 3
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    // waveform from state before this tick's advance
    always_comb begin
        case (ctrl.shape)
            synth_pkg::SHAPE_SQUARE: begin
                wave = phase[PHASE_W-1] ? SQUARE_LO : SQUARE_HI;
            end
            synth_pkg::SHAPE_SAW: begin
                wave = $signed(phase[PHASE_W-1 -: SAMPLE_W]);
            end
            synth_pkg::SHAPE_NOISE: begin
                wave = $signed(lfsr);
            end
            default: begin
                wave = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= '0;
            lfsr         <= SEED;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= ctrl.tick;
            if (restart) begin
                phase <= '0;
            end else if (advance) begin
                phase <= phase + STEP;
            end
            if (advance) begin
                lfsr <= {lfsr[6:0], lfsr_fb};  // noise runs on across a restart
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.tick) begin
            sample <= gate ? wave : '0;  // silent voice adds nothing
        end
    end

endmodule

/* hw/synth_control.sv */
`timescale 1ns/1ps

module synth_control #(
    parameter int NUM_VOICES = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  synth_pkg::key_event_t           key,
    input  logic                            set_settings,
    input  synth_pkg::synth_settings_t      settings,
    input  logic                            sample_clock,
    output synth_pkg::voice_ctrl_t          ctrl,
    output logic [NUM_VOICES-1:0]           gate,
    output logic [NUM_VOICES-1:0]           restart,
    output logic [synth_pkg::VOLUME_W-1:0]  volume
);

    logic                       sample_clock_q;
    logic                       tick;
    synth_pkg::synth_settings_t settings_q;
    logic [NUM_VOICES-1:0]      note_sel;

    // one-hot select of the addressed note
    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            note_sel[i] = (int'(key.note) == i); // notes past the voice count hit nothing
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_clock_q <= 1'b1;   // a level already high is no edge
            tick           <= 1'b0;
        end else begin
            sample_clock_q <= sample_clock;
            tick           <= sample_clock & ~sample_clock_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gate    <= '0;
            restart <= '0;
        end else begin
            restart <= key.press ? note_sel : '0; // phase cleared one edge later
            if (key.press) begin
                gate <= gate | note_sel;
            end else if (key.rel) begin
                gate <= gate & ~note_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            settings_q.shape  <= synth_pkg::SHAPE_SQUARE;
            settings_q.volume <= '1;  // full volume
        end else if (set_settings) begin
            settings_q <= settings;
        end
    end

    assign ctrl   = '{tick: tick, shape: settings_q.shape};
    assign volume = settings_q.volume;

endmodule

/* hw/synth_pkg.sv */
package synth_pkg;

    localparam int NOTE_W   = 3;
    localparam int PHASE_W  = 16;
    localparam int SAMPLE_W = 8;
    localparam int VOLUME_W = 2;

    // upper bits set so xor with a voice index never gives zero
    localparam logic [7:0] LFSR_SEED = 8'hb4;

    typedef enum logic [1:0] {
        SHAPE_SQUARE = 2'd0,
        SHAPE_SAW    = 2'd1,
        SHAPE_NOISE  = 2'd2
    } osc_shape_t;

    typedef struct packed {
        logic              press;
        logic              rel;    // key release strobe
        logic [NOTE_W-1:0] note;
    } key_event_t;

    typedef struct packed {
        osc_shape_t          shape;
        logic [VOLUME_W-1:0] volume;
    } synth_settings_t;

    typedef struct packed {
        logic       tick;   // one cycle per sample clock rise
        osc_shape_t shape;
    } voice_ctrl_t;

    // phase step per note, odd so every phase value is visited
    function automatic logic [PHASE_W-1:0] note_increment(
        input logic [NOTE_W-1:0] note
    );
        logic [PHASE_W-1:0] step;

        case (note)
            3'd0:    step = 16'd1097;
            3'd1:    step = 16'd1163;
            3'd2:    step = 16'd1231;
            3'd3:    step = 16'd1305;
            3'd4:    step = 16'd1383;
            3'd5:    step = 16'd1465;
            3'd6:    step = 16'd1553;
            default: step = 16'd1645;
        endcase
        return step;
    endfunction

endpackage
